// File: flist.f
hdl/tlp_pkg.sv
hdl/bar_pkg.sv
hdl/rx_frame_if.sv
hdl/tlp_rx_decoder.sv
hdl/tlp_handler_ctrl.sv
hdl/tlp_completion_builder.sv
hdl/tlp_stats_csr.sv
hdl/pcie_bar_handler.sv
verification/tb_clock_gen.sv
verification/pcie_bar_handler_tb.sv

// File: Bender.yml
package:
  name: pcie_bar_handler

sources:
  - hdl/tlp_pkg.sv
  - hdl/bar_pkg.sv
  - hdl/rx_frame_if.sv
  - hdl/tlp_rx_decoder.sv
  - hdl/tlp_handler_ctrl.sv
  - hdl/tlp_completion_builder.sv
  - hdl/tlp_stats_csr.sv
  - hdl/pcie_bar_handler.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/pcie_bar_handler_tb.sv

// File: verification/pcie_bar_handler_tb.sv
//####################
// Directed tests of the BAR handler, single-beat 3DW requests only
// Outputs are sampled on the falling edge, inputs driven on the rising edge
// Latencies are counted from the cycle the beat sits on the RX bus
//####################
module pcie_bar_handler_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import tlp_pkg::*;
  import bar_pkg::*;

  localparam int unsigned BAR_ADDR_BITS = 16;
  localparam int TIMEOUT_CYCLES = 2000;  // Tests take about 150 cycles
  localparam int PULSE_WAIT     = 20;    // Per awaited pulse
  localparam int EV_REQ     = 0;         // Pulse kinds seen by the monitor
  localparam int EV_INST    = 1;
  localparam int EV_RESP    = 2;
  localparam int EV_ERR_PR  = 3;
  localparam int EV_ERR_NPR = 4;

  logic clk, reset, my_id_valid, rx_valid, rx_sop, rx_eop, rx_ready;
  logic req_valid, resp_valid, resp_ready, csr_read;
  logic inst_valid, inst_sop, inst_eop, tx_valid, tx_sop, tx_eop;
  logic [1:0] cpl_err;
  pcie_id_t   my_id;
  tlp_beat_t  rx_data, inst_data, tx_data, inst_beat, resp_beat;
  tlp_empty_t inst_empty, tx_empty, inst_empty_seen, resp_empty_seen;
  mem_req_t   req_data, req_seen;
  mem_resp_t  resp_data;
  csr_addr_t  csr_address;
  csr_data_t  csr_readdata;
  logic inst_single, resp_single;        // Start and end on the same beat
  logic [31:0] rng;
  int errors = 0;
  int checks = 0;
  int cycle  = 0;
  int beat_cycle;
  int pulse_count [5];
  int pulse_cycle [5];
  int sent_tlps = 0;                     // Own event tally for the CSR test
  int unsup_frames = 0;
  int inst_cpls = 0;
  int resp_cpls = 0;

  tb_clock_gen clock_gen_i (.clk(clk), .reset(reset));

  pcie_bar_handler #(.BAR_ADDR_BITS(BAR_ADDR_BITS)) pcie_bar_handler_i (
    .clk(clk), .reset(reset), .my_id(my_id), .my_id_valid(my_id_valid),
    .tlp_rx_st_data(rx_data), .tlp_rx_st_valid(rx_valid),
    .tlp_rx_st_startofpacket(rx_sop), .tlp_rx_st_endofpacket(rx_eop),
    .tlp_rx_st_ready(rx_ready),
    .mem_access_req_valid(req_valid), .mem_access_req_data(req_data),
    .mem_access_resp_valid(resp_valid), .mem_access_resp_data(resp_data),
    .mem_access_resp_ready(resp_ready),
    .tlp_tx_instant_st_valid(inst_valid), .tlp_tx_instant_st_startofpacket(inst_sop),
    .tlp_tx_instant_st_endofpacket(inst_eop), .tlp_tx_instant_st_data(inst_data),
    .tlp_tx_instant_st_empty(inst_empty),
    .tlp_tx_response_st_valid(tx_valid), .tlp_tx_response_st_startofpacket(tx_sop),
    .tlp_tx_response_st_endofpacket(tx_eop), .tlp_tx_response_st_data(tx_data),
    .tlp_tx_response_st_empty(tx_empty),
    .cpl_err(cpl_err), .csr_read(csr_read), .csr_address(csr_address),
    .csr_readdata(csr_readdata)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // 3DW MRd or MWr, payload qword aligned after the header
  function automatic tlp_beat_t mem_request(input logic write, input tlp_len_t len,
      input pcie_id_t rid, input tlp_tag_t tag, input logic [31:0] addr, input tlp_dw_t data);
    tlp_dw_t [7:0] b;
    b = '0;
    b[0] = {write ? 3'b010 : 3'b000, 5'b00000, 14'b0, len};
    b[1] = {rid, tag, (len == 10'd1) ? 4'h0 : 4'hf, 4'hf};  // Last BE zero for 1 DW
    b[2] = {addr[31:2], 2'b00};
    if (write && addr[2]) b[3] = data;
    else if (write) b[4] = data;
    return b;
  endfunction

  function automatic mem_req_t expected_req(input logic write, input pcie_id_t rid,
      input tlp_tag_t tag, input logic [31:0] addr, input tlp_dw_t data);
    mem_req_t r;
    logic [63:0] masked;
    r = '0;
    masked = {32'b0, addr[31:2], 2'b00} & ((64'd1 << BAR_ADDR_BITS) - 1);
    r[0] = write;
    if (write) r[32:1] = data;
    else r[24:1] = {tag, rid};
    r[94:33] = masked[63:2];
    return r;
  endfunction

  // Cpl or CplD beat as the completer should send it
  function automatic tlp_beat_t expected_cpl(input logic with_data, input tlp_len_t len,
      input logic [2:0] status, input byte_count_t bc, input pcie_id_t rid,
      input tlp_tag_t tag, input logic [6:0] lower, input tlp_dw_t data);
    tlp_dw_t [7:0] b;
    b = '0;
    b[0] = {with_data ? 3'b010 : 3'b000, 5'b01010, 14'b0, len};
    b[1] = {my_id, status, 1'b0, bc};
    b[2] = {rid, tag, 1'b0, lower};
    if (with_data && lower[2]) b[3] = data;
    else if (with_data) b[4] = data;
    return b;
  endfunction

  task automatic check_value(input string name, input logic [255:0] actual,
                             input logic [255:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic wait_pulse(input int ev, input int target, input string what);
    int waited;
    waited = 0;
    while (pulse_count[ev] < target && waited < PULSE_WAIT) begin
      @(posedge clk);
      waited++;
    end
    if (pulse_count[ev] < target) begin
      errors++;
      $display("Error at %0t ns: no %s pulse within %0d cycles", $time, what, PULSE_WAIT);
    end
  endtask

  task automatic send_tlp(input tlp_beat_t beat);
    @(posedge clk);
    rx_data  <= beat;
    rx_valid <= 1'b1;
    rx_sop   <= 1'b1;
    rx_eop   <= 1'b1;
    beat_cycle = cycle + 1;  // Monitor sees it at the next falling edge
    sent_tlps++;
    @(posedge clk);
    rx_valid <= 1'b0;
    rx_sop   <= 1'b0;
    rx_eop   <= 1'b0;
  endtask

  task automatic read_csr(input csr_addr_t addr, output csr_data_t value);
    @(posedge clk);
    csr_read    <= 1'b1;
    csr_address <= addr;
    @(posedge clk);
    csr_read <= 1'b0;
    @(negedge clk);
    value = csr_readdata;
  endtask

  task automatic reset_and_csr();
    csr_data_t v;
    int waited;
    idle_cycles(2);
    @(negedge clk);
    check_value("tlp_rx_st_ready", rx_ready, 1'b0);  // No ID yet
    check_value("mem_access_resp_ready", resp_ready, 1'b0);
    @(posedge clk);
    my_id_valid <= 1'b1;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!rx_ready && waited < PULSE_WAIT);
    if (!rx_ready) begin
      errors++;
      $display("Error at %0t ns: tlp_rx_st_ready stayed low after my_id_valid", $time);
    end
    check_value("mem_access_resp_ready", resp_ready, 1'b1);  // Follows RX ready
    read_csr(CSR_ID, v);
    check_value("csr_readdata at address 0", v, {16'b0, my_id});
    for (int a = 1; a < 5; a++) begin
      read_csr(csr_addr_t'(a), v);
      check_value($sformatf("csr_readdata at address %0d", a), v, 32'd0);
    end
    read_csr(6'd9, v);
    check_value("csr_readdata at address 9", v, 32'hffff_ffff);  // Unmapped
  endtask

  // Supported 1-DW request, read or write
  task automatic supported_mem(input logic write);
    logic [31:0] addr;
    tlp_dw_t     data;
    int req_before, inst_before;
    rng = xorshift(rng);
    addr = rng;
    rng = xorshift(rng);
    data = rng;
    rng = xorshift(rng);
    req_before  = pulse_count[EV_REQ];
    inst_before = pulse_count[EV_INST];
    send_tlp(mem_request(write, 10'd1, rng[31:16], rng[7:0], addr, data));
    wait_pulse(EV_REQ, req_before + 1, "mem_access_req_valid");
    check_value("mem_access_req_valid latency", pulse_cycle[EV_REQ] - beat_cycle, 2);
    check_value("mem_access_req_data", req_seen,
                expected_req(write, rng[31:16], rng[7:0], addr, data));
    idle_cycles(4);
    check_value("mem_access_req_valid pulses", pulse_count[EV_REQ], req_before + 1);
    check_value("tlp_tx_instant_st_valid pulses", pulse_count[EV_INST], inst_before);
  endtask

  task automatic unsupported_requests();
    logic [31:0] addr;
    int npr_before, pr_before, inst_before, req_before;
    rng = xorshift(rng);
    addr = rng;
    rng = xorshift(rng);
    npr_before  = pulse_count[EV_ERR_NPR];
    pr_before   = pulse_count[EV_ERR_PR];
    inst_before = pulse_count[EV_INST];
    send_tlp(mem_request(1'b0, 10'd2, rng[31:16], rng[7:0], addr, '0));  // MRd, 2 DW
    unsup_frames++;
    wait_pulse(EV_ERR_NPR, npr_before + 1, "cpl_err[1]");
    check_value("cpl_err[1] latency", pulse_cycle[EV_ERR_NPR] - beat_cycle, 1);
    wait_pulse(EV_INST, inst_before + 1, "tlp_tx_instant_st_valid");
    inst_cpls++;
    check_value("tlp_tx_instant_st_valid latency", pulse_cycle[EV_INST] - beat_cycle, 3);
    check_value("tlp_tx_instant_st_data", inst_beat, expected_cpl(1'b0, 10'd0, 3'b001,
                12'd8, rng[31:16], rng[7:0], {addr[6:2], 2'b00}, '0));
    check_value("tlp_tx_instant_st_empty", inst_empty_seen, 3'd5);
    check_value("tlp_tx_instant_st start and end", inst_single, 1'b1);
    check_value("cpl_err[0] pulses", pulse_count[EV_ERR_PR], pr_before);
    // Posted request, error pulse only
    npr_before  = pulse_count[EV_ERR_NPR];
    inst_before = pulse_count[EV_INST];
    req_before  = pulse_count[EV_REQ];
    send_tlp(mem_request(1'b1, 10'd2, rng[31:16], rng[7:0], addr, rng));
    unsup_frames++;
    wait_pulse(EV_ERR_PR, pr_before + 1, "cpl_err[0]");
    check_value("cpl_err[0] latency", pulse_cycle[EV_ERR_PR] - beat_cycle, 1);
    idle_cycles(5);
    check_value("cpl_err[1] pulses", pulse_count[EV_ERR_NPR], npr_before);
    check_value("tlp_tx_instant_st_valid pulses", pulse_count[EV_INST], inst_before);
    check_value("mem_access_req_valid pulses", pulse_count[EV_REQ], req_before);
  endtask

  task automatic read_completions();
    logic [6:0] lower;
    int resp_before;
    for (int b = 0; b < 2; b++) begin
      rng = xorshift(rng);
      lower = {rng[3:0], b[0], 2'b00};  // Bit 2 picks the data dword
      resp_before = pulse_count[EV_RESP];
      @(posedge clk);
      resp_valid <= 1'b1;
      resp_data  <= {64'b0, rng, 3'b0, lower[6:2], rng[15:8], rng[31:16]};
      beat_cycle = cycle + 1;
      @(posedge clk);
      resp_valid <= 1'b0;
      wait_pulse(EV_RESP, resp_before + 1, "tlp_tx_response_st_valid");
      resp_cpls++;
      check_value("tlp_tx_response_st_valid latency", pulse_cycle[EV_RESP] - beat_cycle, 1);
      check_value("tlp_tx_response_st_data", resp_beat, expected_cpl(1'b1, 10'd1, 3'b000,
                  12'd4, rng[31:16], rng[15:8], lower, rng));
      check_value("tlp_tx_response_st_empty", resp_empty_seen, b ? 3'd4 : 3'd3);
      check_value("tlp_tx_response_st start and end", resp_single, 1'b1);
    end
  endtask

  task automatic counter_readback();
    csr_data_t v;
    read_csr(CSR_RX_COUNT, v);
    check_value("RX TLP count", v, sent_tlps);
    read_csr(CSR_UNSUP_COUNT, v);
    check_value("unsupported count", v, unsup_frames);
    read_csr(CSR_INST_COUNT, v);
    check_value("instant TX count", v, inst_cpls);
    read_csr(CSR_RESP_COUNT, v);
    check_value("response TX count", v, resp_cpls);
  endtask

  // Pulse monitor, falling edge so registered outputs are settled
  always @(negedge clk) begin
    if (!reset) begin
      if (req_valid) begin
        pulse_count[EV_REQ]++;
        pulse_cycle[EV_REQ] = cycle;
        req_seen = req_data;
      end
      if (inst_valid) begin
        pulse_count[EV_INST]++;
        pulse_cycle[EV_INST] = cycle;
        inst_beat = inst_data;
        inst_empty_seen = inst_empty;
        inst_single = inst_sop & inst_eop;
      end
      if (tx_valid) begin
        pulse_count[EV_RESP]++;
        pulse_cycle[EV_RESP] = cycle;
        resp_beat = tx_data;
        resp_empty_seen = tx_empty;
        resp_single = tx_sop & tx_eop;
      end
      if (cpl_err[0]) begin
        pulse_count[EV_ERR_PR]++;
        pulse_cycle[EV_ERR_PR] = cycle;
      end
      if (cpl_err[1]) begin
        pulse_count[EV_ERR_NPR]++;
        pulse_cycle[EV_ERR_NPR] = cycle;
      end
    end
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    foreach (pulse_count[i]) begin
      pulse_count[i] = 0;
      pulse_cycle[i] = 0;
    end
    rng = 32'h47e6382b;
    rng = xorshift(rng);
    my_id       = rng[15:0];
    my_id_valid = 1'b0;
    rx_data     = '0;
    rx_valid    = 1'b0;
    rx_sop      = 1'b0;
    rx_eop      = 1'b0;
    resp_valid  = 1'b0;
    resp_data   = '0;
    csr_read    = 1'b0;
    csr_address = '0;
    @(negedge reset);
    reset_and_csr();
    supported_mem(1'b1);  // MWr
    supported_mem(1'b0);  // MRd
    unsupported_requests();
    read_completions();
    counter_readback();
    $display("Closing: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: verification/tb_clock_gen.sv
//####################
// Testbench clock and synchronous reset
// 100 ns period, reset high for RESET_CYCLES rising edges
//####################
module tb_clock_gen #(
  parameter int RESET_CYCLES = 8,
  parameter int HALF_PERIOD  = 50
) (
  output logic clk,
  output logic reset = 1'b1  // High from time zero, no edge at start
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;  // Released on an edge like any other input
  end

endmodule

// File: hdl/pcie_bar_handler.sv
//####################
// BAR-side TLP handler, 256-bit Avalon-ST, ready latency zero
// TX streams and mem_access_req have no ready, a downstream stall loses data
// Only 1-DW 3DW MRd/MWr are served, the rest is handled as UR
// BAR_ADDR_BITS must be at least 7
//####################
module pcie_bar_handler #(
  parameter int unsigned BAR_ADDR_BITS = 16
) (
  input  logic                clk,
  input  logic                reset,
  input  tlp_pkg::pcie_id_t   my_id,
  input  logic                my_id_valid,
  input  tlp_pkg::tlp_beat_t  tlp_rx_st_data,
  input  logic                tlp_rx_st_valid,
  input  logic                tlp_rx_st_startofpacket,
  input  logic                tlp_rx_st_endofpacket,
  output logic                tlp_rx_st_ready,
  output logic                mem_access_req_valid,
  output bar_pkg::mem_req_t   mem_access_req_data,
  input  logic                mem_access_resp_valid,
  input  bar_pkg::mem_resp_t  mem_access_resp_data,
  output logic                mem_access_resp_ready,
  output logic                tlp_tx_instant_st_valid,
  output logic                tlp_tx_instant_st_startofpacket,
  output logic                tlp_tx_instant_st_endofpacket,
  output tlp_pkg::tlp_beat_t  tlp_tx_instant_st_data,
  output tlp_pkg::tlp_empty_t tlp_tx_instant_st_empty,
  output logic                tlp_tx_response_st_valid,
  output logic                tlp_tx_response_st_startofpacket,
  output logic                tlp_tx_response_st_endofpacket,
  output tlp_pkg::tlp_beat_t  tlp_tx_response_st_data,
  output tlp_pkg::tlp_empty_t tlp_tx_response_st_empty,
  output logic [1:0]          cpl_err,          // Bit 1 UR non-posted, bit 0 UR posted
  input  logic                csr_read,
  input  bar_pkg::csr_addr_t  csr_address,
  output bar_pkg::csr_data_t  csr_readdata
);

  logic rx_enable;
  logic rx_accept;
  logic ur_send;
  logic unsupported_end;
  logic instant_sent;
  logic response_sent;

  rx_frame_if frame ();

  assign tlp_rx_st_ready       = rx_enable;
  assign mem_access_resp_ready = rx_enable;

  tlp_rx_decoder #(
    .BAR_ADDR_BITS(BAR_ADDR_BITS)
  ) decoder_i (
    .clk      (clk),
    .reset    (reset),
    .rx_enable(rx_enable),
    .rx_valid (tlp_rx_st_valid),
    .rx_sop   (tlp_rx_st_startofpacket),
    .rx_eop   (tlp_rx_st_endofpacket),
    .rx_data  (tlp_rx_st_data),
    .rx_accept(rx_accept),
    .frame    (frame.source)
  );

  tlp_handler_ctrl ctrl_i (
    .clk            (clk),
    .reset          (reset),
    .my_id_valid    (my_id_valid),
    .frame          (frame.sink),
    .rx_enable      (rx_enable),
    .ur_send        (ur_send),
    .unsupported_end(unsupported_end),
    .cpl_err        (cpl_err),
    .mem_req_valid  (mem_access_req_valid),
    .mem_req        (mem_access_req_data)
  );

  tlp_completion_builder builder_i (
    .clk          (clk),
    .reset        (reset),
    .my_id        (my_id),
    .ur_send      (ur_send),
    .frame        (frame.sink),
    .resp_valid   (mem_access_resp_valid),
    .resp         (mem_access_resp_data),
    .inst_valid   (tlp_tx_instant_st_valid),
    .inst_sop     (tlp_tx_instant_st_startofpacket),
    .inst_eop     (tlp_tx_instant_st_endofpacket),
    .inst_data    (tlp_tx_instant_st_data),
    .inst_empty   (tlp_tx_instant_st_empty),
    .resp_tx_valid(tlp_tx_response_st_valid),
    .resp_tx_sop  (tlp_tx_response_st_startofpacket),
    .resp_tx_eop  (tlp_tx_response_st_endofpacket),
    .resp_tx_data (tlp_tx_response_st_data),
    .resp_tx_empty(tlp_tx_response_st_empty),
    .instant_sent (instant_sent),
    .response_sent(response_sent)
  );

  tlp_stats_csr stats_i (
    .clk            (clk),
    .reset          (reset),
    .my_id          (my_id),
    .rx_accept      (rx_accept),
    .unsupported_end(unsupported_end),
    .instant_sent   (instant_sent),
    .response_sent  (response_sent),
    .csr_read       (csr_read),
    .csr_address    (csr_address),
    .csr_readdata   (csr_readdata)
  );

endmodule

// File: hdl/tlp_stats_csr.sv
//####################
// Event counters and the CSR read port
// Read data comes one cycle after csr_read and holds until the next read
// Counters wrap silently
//####################
module tlp_stats_csr (
  input  logic               clk,
  input  logic               reset,
  input  tlp_pkg::pcie_id_t  my_id,
  input  logic               rx_accept,
  input  logic               unsupported_end,
  input  logic               instant_sent,
  input  logic               response_sent,
  input  logic               csr_read,
  input  bar_pkg::csr_addr_t csr_address,
  output bar_pkg::csr_data_t csr_readdata
);
  import bar_pkg::*;

  logic [3:0]  events;
  stat_count_t counts [4];

  // Same order as the CSR map
  assign events = {response_sent, instant_sent, unsupported_end, rx_accept};

  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (reset) begin
        counts[i] <= '0;
      end else if (events[i]) begin
        counts[i] <= counts[i] + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (csr_read) begin
      case (csr_address)
        CSR_ID:          csr_readdata <= {16'b0, my_id};
        CSR_RX_COUNT:    csr_readdata <= counts[0];
        CSR_UNSUP_COUNT: csr_readdata <= counts[1];
        CSR_INST_COUNT:  csr_readdata <= counts[2];
        CSR_RESP_COUNT:  csr_readdata <= counts[3];
        default:         csr_readdata <= '1;  // Unmapped
      endcase
    end
  end

endmodule

// File: hdl/tlp_completion_builder.sv
//####################
// UR completions on the instant stream, CplD on the response stream
// Ready latency zero and no back-pressure, a stalled sink loses beats
// Every completion is one beat with start and end set
//####################
module tlp_completion_builder (
  input  logic                clk,
  input  logic                reset,
  input  tlp_pkg::pcie_id_t   my_id,
  input  logic                ur_send,
  rx_frame_if.sink            frame,
  input  logic                resp_valid,
  input  bar_pkg::mem_resp_t  resp,
  output logic                inst_valid,
  output logic                inst_sop,
  output logic                inst_eop,
  output tlp_pkg::tlp_beat_t  inst_data,
  output tlp_pkg::tlp_empty_t inst_empty,
  output logic                resp_tx_valid,
  output logic                resp_tx_sop,
  output logic                resp_tx_eop,
  output tlp_pkg::tlp_beat_t  resp_tx_data,
  output tlp_pkg::tlp_empty_t resp_tx_empty,
  output logic                instant_sent,
  output logic                response_sent
);
  import tlp_pkg::*;

  pcie_id_t      ur_rid;       // Copy of the ended frame, a new start may follow
  tlp_tag_t      ur_tag;
  byte_count_t   ur_bc;
  logic [6:0]    ur_lower;
  logic [6:0]    resp_lower;
  tlp_dw_t [7:0] resp_beat;

  // Three-dword completion header, remaining dwords zero
  function automatic tlp_beat_t cpl_header(logic [2:0] fmt, tlp_len_t len,
                                           cpl_status_t status, byte_count_t bc,
                                           pcie_id_t cpl_id, pcie_id_t req_id,
                                           tlp_tag_t tag, logic [6:0] lower);
    tlp_dw_t [7:0] beat;
    beat = '0;
    beat[0] = {fmt, TYPE_CPL, 14'b0, len};
    beat[1] = {cpl_id, status, 1'b0, bc};   // BCM clear
    beat[2] = {req_id, tag, 1'b0, lower};
    return beat;
  endfunction

  always_ff @(posedge clk) begin
    if (frame.frame_end) begin
      ur_rid   <= frame.requester_id;
      ur_tag   <= frame.tag;
      ur_bc    <= frame.byte_count;
      ur_lower <= frame.address[6:0];
    end
  end

  assign resp_lower = {resp[28:24], 2'b00};

  always_comb begin
    resp_beat = cpl_header(FMT_CPLD, 10'd1, SC_OK, 12'd4, my_id, resp[15:0], resp[23:16],
                           resp_lower);
    // Qword aligned address puts data after a pad dword, same as RX
    if (resp_lower[2]) resp_beat[3] = resp[63:32];
    else resp_beat[4] = resp[63:32];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      inst_valid    <= 1'b0;
      resp_tx_valid <= 1'b0;
    end else begin
      inst_valid    <= ur_send;
      resp_tx_valid <= resp_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ur_send) begin
      inst_data  <= cpl_header(FMT_CPL, 10'd0, SC_UR, ur_bc, my_id, ur_rid, ur_tag, ur_lower);
      inst_empty <= 3'd5;  // Header only
    end
    if (resp_valid) begin
      resp_tx_data  <= resp_beat;
      resp_tx_empty <= resp_lower[2] ? 3'd4 : 3'd3;
    end
  end

  // Single beat TLPs
  assign inst_sop      = inst_valid;
  assign inst_eop      = inst_valid;
  assign resp_tx_sop   = resp_tx_valid;
  assign resp_tx_eop   = resp_tx_valid;
  assign instant_sent  = inst_valid;
  assign response_sent = resp_tx_valid;

endmodule

// File: hdl/tlp_handler_ctrl.sv
//####################
// Acceptance gate and routing of finished frames
// mem_req is not flow controlled, the consumer must take every pulse
//####################
module tlp_handler_ctrl (
  input  logic              clk,
  input  logic              reset,
  input  logic              my_id_valid,
  rx_frame_if.sink          frame,
  output logic              rx_enable,
  output logic              ur_send,
  output logic              unsupported_end,
  output logic [1:0]        cpl_err,
  output logic              mem_req_valid,
  output bar_pkg::mem_req_t mem_req
);
  import tlp_pkg::*;

  logic supported_mem;  // 1-DW MRd or MWr that passed every check
  logic ur_start;       // Unsupported frame just decoded

  assign supported_mem = !frame.unsupported &&
                         (frame.kind == TLP_MRD || frame.kind == TLP_MWR);
  assign ur_start = frame.frame_start & frame.unsupported;

  always_ff @(posedge clk) begin
    if (reset) begin
      rx_enable       <= 1'b0;
      ur_send         <= 1'b0;
      unsupported_end <= 1'b0;
      mem_req_valid   <= 1'b0;
    end else begin
      rx_enable       <= my_id_valid;  // Wait until config assigned our ID
      ur_send         <= frame.frame_end & frame.unsupported & frame.is_npr;
      unsupported_end <= frame.frame_end & frame.unsupported;
      mem_req_valid   <= frame.frame_end & supported_mem;
    end
  end

  always_ff @(posedge clk) begin
    if (frame.frame_end && supported_mem) begin
      if (frame.kind == TLP_MWR) begin
        mem_req <= {33'b0, frame.address[63:2], frame.data, 1'b1};
      end else begin
        mem_req <= {33'b0, frame.address[63:2], 8'b0, frame.tag, frame.requester_id, 1'b0};
      end
    end
  end

  // Bit 1 non-posted UR, bit 0 posted UR
  assign cpl_err = {ur_start & frame.is_npr, ur_start & frame.is_pr};

endmodule

// File: hdl/tlp_rx_decoder.sv
//####################
// Header decode of the 256-bit RX stream, header must sit in the start beat
// No abort on a dropped valid, and rx_st_error is not looked at
// BAR_ADDR_BITS must be at least 7 so lower address bits stay intact
//####################
module tlp_rx_decoder #(
  parameter int unsigned BAR_ADDR_BITS = 16
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               rx_enable,
  input  logic               rx_valid,
  input  logic               rx_sop,
  input  logic               rx_eop,
  input  tlp_pkg::tlp_beat_t rx_data,
  output logic               rx_accept,
  rx_frame_if.source         frame
);
  import tlp_pkg::*;

  localparam tlp_addr_t BAR_MASK = (tlp_addr_t'(1) << BAR_ADDR_BITS) - 1;

  tlp_dw_t [7:0] dw;
  logic [2:0]    fmt;
  logic [4:0]    raw_type;
  tlp_len_t      len;
  logic          is_4dw;
  logic [3:0]    first_be;
  logic [3:0]    last_be;
  tlp_kind_e     kind;
  logic          npr;
  logic          pr;
  logic          is_mem;
  tlp_addr_t     address;
  byte_count_t   byte_count;

  // Byte count from length and byte enables, as in the PCIe spec table
  function automatic byte_count_t calc_byte_count(tlp_len_t length, logic [3:0] fbe,
                                                  logic [3:0] lbe);
    int lo;       // Lowest enabled byte, first dword
    int hi_first; // Highest enabled byte, first dword
    int hi_last;  // Highest enabled byte, last dword
    lo = 0;
    hi_first = 0;
    hi_last = 0;
    for (int i = 3; i >= 0; i--) begin
      if (fbe[i]) lo = i;
    end
    for (int i = 0; i < 4; i++) begin
      if (fbe[i]) hi_first = i;
      if (lbe[i]) hi_last = i;
    end
    if (lbe == 4'b0000) begin                       // Single dword
      return (fbe == 4'b0000) ? byte_count_t'(1) : byte_count_t'(hi_first - lo + 1);
    end
    if (fbe == 4'b0000) return '0;                  // Illegal combination
    return byte_count_t'({length, 2'b00} - lo - (3 - hi_last));
  endfunction

  assign dw        = rx_data;
  assign fmt       = dw[0][31:29];
  assign raw_type  = dw[0][28:24];
  assign len       = dw[0][9:0];
  assign is_4dw    = fmt[0];
  assign first_be  = dw[1][3:0];
  assign last_be   = dw[1][7:4];
  assign rx_accept = rx_enable & rx_valid & rx_sop;

  always_comb begin
    case ({fmt[1], raw_type})
      6'b000000: kind = TLP_MRD;
      6'b000001: kind = TLP_MRDLK;
      6'b100000: kind = TLP_MWR;
      6'b001010: kind = TLP_CPL;
      6'b101010: kind = TLP_CPLD;
      default:   kind = TLP_UNKNOWN;
    endcase
  end

  // Posted vs non-posted, from the raw codes so unknown kinds still classify
  always_comb begin
    npr = 1'b0;
    pr  = 1'b0;
    casez ({fmt[1], raw_type})
      6'b00000?: npr = 1'b1;  // MRd, MRdLk
      6'b?00010: npr = 1'b1;  // IORd, IOWr
      6'b1011??: npr = 1'b1;  // AtomicOp
      6'b100000: pr  = 1'b1;  // MWr
      6'b?10???: pr  = 1'b1;  // Msg, MsgD
      default: ;
    endcase
  end

  assign is_mem     = (kind == TLP_MRD) || (kind == TLP_MWR);
  assign address    = is_4dw ? {dw[2], dw[3][31:2], 2'b00} : {32'b0, dw[2][31:2], 2'b00};
  assign byte_count = calc_byte_count(len, first_be, last_be);

  always_ff @(posedge clk) begin
    if (reset) begin
      frame.frame_start <= 1'b0;
      frame.frame_end   <= 1'b0;
    end else begin
      frame.frame_start <= rx_accept;
      frame.frame_end   <= rx_enable & rx_valid & rx_eop;
    end
  end

  always_ff @(posedge clk) begin
    if (rx_accept) begin
      frame.kind <= kind;
      if (kind == TLP_CPL || kind == TLP_CPLD) begin  // IDs shift down one dword
        frame.tag          <= dw[2][15:8];
        frame.requester_id <= dw[2][31:16];
      end else begin
        frame.tag          <= dw[1][15:8];
        frame.requester_id <= dw[1][31:16];
      end
      frame.address <= address & BAR_MASK;
      // 3DW payload is qword aligned, dword 3 only when address bit 2 is set
      frame.data       <= (!is_4dw && dw[2][2]) ? dw[3] : dw[4];
      frame.byte_count <= byte_count;
      frame.is_npr     <= npr;
      frame.is_pr      <= pr;
      frame.unsupported <= (kind inside {TLP_UNKNOWN, TLP_CPL, TLP_MRDLK}) || is_4dw ||
                           (is_mem && (len != 10'd1 || !(byte_count inside {12'd0, 12'd4})));
    end
  end

endmodule

// File: hdl/rx_frame_if.sv
//####################
// Decoded RX frame, fields valid from frame_start to the next start
//####################
interface rx_frame_if;
  import tlp_pkg::*;

  logic        frame_start;  // Pulse, header fields just loaded
  logic        frame_end;    // Pulse, last beat seen
  tlp_kind_e   kind;
  tlp_tag_t    tag;
  pcie_id_t    requester_id;
  tlp_addr_t   address;      // Already masked to the BAR window
  tlp_dw_t     data;         // Write payload, single dword
  byte_count_t byte_count;
  logic        is_npr;       // Needs a completion
  logic        is_pr;
  logic        unsupported;

  modport source (output frame_start, frame_end, kind, tag, requester_id, address, data,
                  byte_count, is_npr, is_pr, unsupported);
  modport sink (input frame_start, frame_end, kind, tag, requester_id, address, data,
                byte_count, is_npr, is_pr, unsupported);
endinterface

// File: hdl/bar_pkg.sv
//####################
// Memory-access request/response layout and CSR register map
// Request: bit 0 write, read 16:1 req ID 24:17 tag, write 32:1 data,
//   94:33 address 63:2, all else zero
// Response: 15:0 req ID, 23:16 tag, 28:24 address 6:2, 63:32 read data
//####################
package bar_pkg;

  typedef logic [127:0] mem_req_t;
  typedef logic [127:0] mem_resp_t;
  typedef logic [5:0]   csr_addr_t;
  typedef logic [31:0]  csr_data_t;
  typedef logic [31:0]  stat_count_t;

  // CSR map, anything else reads all ones
  localparam csr_addr_t CSR_ID          = 6'd0;  // my_id in the low half
  localparam csr_addr_t CSR_RX_COUNT    = 6'd1;  // Accepted TLPs
  localparam csr_addr_t CSR_UNSUP_COUNT = 6'd2;  // Unsupported frames
  localparam csr_addr_t CSR_INST_COUNT  = 6'd3;  // UR completions sent
  localparam csr_addr_t CSR_RESP_COUNT  = 6'd4;  // CplD sent

endpackage

// File: hdl/tlp_pkg.sv
//####################
// PCIe TLP field types and the fixed codes used to build completions
// Beats are 256 bit, dword 0 in bits 31:0, header dwords first
// Request header: dw0 fmt/type/length, dw1 requester ID/tag/BEs, dw2.. address
//####################
package tlp_pkg;

  typedef logic [255:0] tlp_beat_t;    // Eight dwords per beat
  typedef logic [31:0]  tlp_dw_t;
  typedef logic [9:0]   tlp_len_t;     // Dwords, 0 encodes 1024
  typedef logic [7:0]   tlp_tag_t;
  typedef logic [15:0]  pcie_id_t;     // Bus, device, function
  typedef logic [11:0]  byte_count_t;
  typedef logic [2:0]   tlp_empty_t;   // Unused dwords in the last beat
  typedef logic [63:0]  tlp_addr_t;    // Byte address, 3DW uses the low half
  typedef logic [2:0]   cpl_status_t;

  // Kinds the handler tells apart, the rest is unknown
  typedef enum logic [2:0] {
    TLP_MRD,
    TLP_MRDLK,
    TLP_MWR,
    TLP_CPL,
    TLP_CPLD,
    TLP_UNKNOWN
  } tlp_kind_e;

  // Completion fmt and type
  localparam logic [2:0] FMT_CPL  = 3'b000;  // 3DW header, no data
  localparam logic [2:0] FMT_CPLD = 3'b010;  // 3DW header with data
  localparam logic [4:0] TYPE_CPL = 5'b01010;

  // Completion status
  localparam cpl_status_t SC_OK = 3'b000;
  localparam cpl_status_t SC_UR = 3'b001;    // Unsupported request

endpackage
